/* source/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    // FIFO geometry, one slot always left free
    localparam int FIFO_DEPTH_LOG2 = 4;
    localparam int FIFO_DEPTH = 2 ** FIFO_DEPTH_LOG2;

    typedef logic [FIFO_DEPTH_LOG2-1:0] count_t;
    typedef logic [2:0] thresh_t;
    typedef logic [30:0] scaler_t;   // Clock cycles per half bit

    // Word addresses
    localparam logic [2:0] REG_TXDATA = 3'd0;
    localparam logic [2:0] REG_RXDATA = 3'd1;
    localparam logic [2:0] REG_TXCTRL = 3'd2;
    localparam logic [2:0] REG_RXCTRL = 3'd3;
    localparam logic [2:0] REG_IE     = 3'd4;
    localparam logic [2:0] REG_IP     = 3'd5;
    localparam logic [2:0] REG_SCALER = 3'd6;

    localparam int FLAG_BIT   = 31;  // Full on txdata, empty on rxdata
    localparam int PERR_BIT   = 8;
    localparam int FERR_BIT   = 9;
    localparam int THRESH_LSB = 16;

    typedef struct packed {
        logic ena;
        logic nstop;  // Set for two stop bits
        logic par;
    } line_cfg_t;

    typedef struct packed {
        logic       perr;
        logic       ferr;
        logic [7:0] data;
    } rx_entry_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* source/byte_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic             i_clk,
    input  wire logic             i_nrst,
    input  wire logic             i_push,
    input  wire payload_t         i_data,
    input  wire logic             i_pop,
    output payload_t              o_data,
    output logic                  o_empty,
    output logic                  o_full,
    output uart_pkg::count_t      o_count
);

    payload_t mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [uart_pkg::FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic do_push;
    logic do_pop;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = ((wr_ptr + 1'b1) == rd_ptr);  // Write would catch the reader
    assign o_count = wr_ptr - rd_ptr;
    assign o_data  = mem[rd_ptr];

    assign do_push = i_push & ~o_full;
    assign do_pop  = i_pop & ~o_empty;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* source/baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module baud_gen (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire uart_pkg::scaler_t i_scaler,
    input  wire logic              i_restart,
    input  wire logic              i_rd,
    input  wire logic              i_rx_idle,
    input  wire logic              i_tx_idle,
    input  wire logic              i_tx_empty,
    output logic                   o_tx_tick,
    output logic                   o_rx_tick
);

    uart_pkg::scaler_t cnt;
    logic level;
    logic quiet;
    logic term;

    // Nothing on either side, keep phase ready for the next start edge
    assign quiet = i_rx_idle & i_rd & i_tx_idle & i_tx_empty;
    assign term  = (i_scaler != '0) & ~quiet & (cnt == i_scaler - 31'd1);

    assign o_tx_tick = term & ~level;  // Toggle to high
    assign o_rx_tick = term & level;   // Toggle to low

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt   <= '0;
            level <= 1'b1;
        end else if (i_restart) begin
            cnt <= '0;
        end else if (i_scaler != '0) begin
            if (quiet) begin
                cnt   <= '0;
                level <= 1'b1;
            end else if (term) begin
                cnt   <= '0;
                level <= ~level;
            end else begin
                cnt <= cnt + 31'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic                i_clk,
    input  wire logic                i_nrst,
    input  wire logic                i_tick,
    input  wire uart_pkg::line_cfg_t i_cfg,
    input  wire logic                i_empty,
    input  wire logic [7:0]          i_data,
    output logic                     o_pop,
    output logic                     o_td,
    output logic                     o_idle
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_t;

    state_t state;
    logic [10:0] shift;
    logic [2:0] bit_cnt;
    logic stop_cnt;   // Second stop bit still to go
    logic load;

    // Start a frame from idle or straight after the last stop bit
    assign load = i_tick & i_cfg.ena & ~i_empty
                & ((state == ST_IDLE) | ((state == ST_STOP) & ~stop_cnt));

    assign o_pop  = load;
    assign o_td   = shift[0];
    assign o_idle = (state == ST_IDLE);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            shift    <= '1;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
        end else if (load) begin
            // stop, parity, data, start
            shift <= {1'b1, (i_cfg.par ? ^i_data : 1'b1), i_data, 1'b0};
            state <= ST_START;
        end else if (i_tick) begin
            shift <= {1'b1, shift[10:1]};  // Ones fill behind the frame
            case (state)
                ST_START: begin
                    state   <= ST_DATA;
                    bit_cnt <= '0;
                end
                ST_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state    <= i_cfg.par ? ST_PARITY : ST_STOP;
                        stop_cnt <= i_cfg.nstop;
                    end
                end
                ST_PARITY: state <= ST_STOP;
                ST_STOP: begin
                    if (stop_cnt) begin
                        stop_cnt <= 1'b0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire logic                i_clk,
    input  wire logic                i_nrst,
    input  wire logic                i_tick,
    input  wire uart_pkg::line_cfg_t i_cfg,
    input  wire logic                i_rd,
    output logic                     o_push,
    output uart_pkg::rx_entry_t      o_entry,
    output logic                     o_idle
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,
        ST_PARITY,
        ST_STOP
    } state_t;

    state_t state;
    logic [7:0] shift;
    logic [2:0] bit_cnt;
    logic stop_cnt;
    logic perr;

    assign o_idle = (state == ST_IDLE);

    // Last stop sample, line level decides the framing error
    assign o_push  = i_tick & (state == ST_STOP) & ~stop_cnt;
    assign o_entry = '{perr: perr, ferr: ~i_rd, data: shift};

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state    <= ST_IDLE;
            bit_cnt  <= '0;
            stop_cnt <= 1'b0;
        end else if (i_tick) begin
            case (state)
                ST_IDLE: begin
                    if (i_cfg.ena && !i_rd) begin  // Middle of start bit
                        state   <= ST_DATA;
                        bit_cnt <= '0;
                    end
                end
                ST_DATA: begin
                    bit_cnt <= bit_cnt + 3'd1;
                    if (bit_cnt == 3'd7) begin
                        state    <= i_cfg.par ? ST_PARITY : ST_STOP;
                        stop_cnt <= i_cfg.nstop;
                    end
                end
                ST_PARITY: state <= ST_STOP;
                ST_STOP: begin
                    if (stop_cnt) begin
                        stop_cnt <= 1'b0;
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge i_clk) begin
        if (i_tick) begin
            case (state)
                ST_IDLE:   perr <= 1'b0;
                ST_DATA:   shift <= {i_rd, shift[7:1]};
                ST_PARITY: perr <= (i_rd != ^shift);
                default:   ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/uart_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
    input  wire logic                i_clk,
    input  wire logic                i_nrst,
    input  wire uart_pkg::wb_req_t   i_wb,
    output uart_pkg::wb_rsp_t        o_wb,
    input  wire logic                i_tx_pop,
    input  wire logic                i_rx_push,
    input  wire uart_pkg::rx_entry_t i_rx_entry,
    output uart_pkg::line_cfg_t      o_tx_cfg,
    output uart_pkg::line_cfg_t      o_rx_cfg,
    output logic                     o_tx_empty,
    output logic [7:0]               o_tx_data,
    output uart_pkg::scaler_t        o_scaler,
    output logic                     o_scaler_restart,
    output logic                     o_irq
);

    uart_pkg::thresh_t tx_thresh, rx_thresh;
    uart_pkg::count_t tx_count, rx_count;
    uart_pkg::rx_entry_t rx_head;
    logic tx_full, rx_empty;
    logic [1:0] ie, ip;  // Bit 0 tx, bit 1 rx
    logic [1:0] ie_nxt, ip_nxt;
    logic acc, wr, tx_push, rx_pop;
    logic ack_q;
    logic [31:0] rdata, dat_q;

    function automatic logic [31:0] ctrl_word(uart_pkg::line_cfg_t cfg, uart_pkg::thresh_t th);
        logic [31:0] w;
        w = '0;
        w[0] = cfg.ena;
        w[1] = cfg.nstop;
        w[2] = cfg.par;
        w[uart_pkg::THRESH_LSB +: $bits(uart_pkg::thresh_t)] = th;
        return w;
    endfunction

    assign acc     = i_wb.cyc & i_wb.stb & ~ack_q;
    assign wr      = acc & i_wb.we;
    assign tx_push = wr & (i_wb.adr == uart_pkg::REG_TXDATA);  // Dropped in the FIFO when full
    assign rx_pop  = acc & ~i_wb.we & (i_wb.adr == uart_pkg::REG_RXDATA);
    assign o_scaler_restart = wr & (i_wb.adr == uart_pkg::REG_SCALER);

    byte_fifo #(.payload_t(logic [7:0])) u_tx_fifo (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_push(tx_push), .i_data(i_wb.dat[7:0]), .i_pop(i_tx_pop),
        .o_data(o_tx_data), .o_empty(o_tx_empty), .o_full(tx_full), .o_count(tx_count)
    );

    byte_fifo #(.payload_t(uart_pkg::rx_entry_t)) u_rx_fifo (
        .i_clk(i_clk), .i_nrst(i_nrst),
        .i_push(i_rx_push), .i_data(i_rx_entry), .i_pop(rx_pop),
        .o_data(rx_head), .o_empty(rx_empty), .o_full(), .o_count(rx_count)
    );

    // Pending bits only live while their enable is set
    always_comb begin
        ie_nxt = (wr && i_wb.adr == uart_pkg::REG_IE) ? i_wb.dat[1:0] : ie;
        ip_nxt = ip;
        if (tx_count < {1'b0, tx_thresh}) ip_nxt[0] = 1'b1;
        if (rx_count > {1'b0, rx_thresh}) ip_nxt[1] = 1'b1;
        if (wr && i_wb.adr == uart_pkg::REG_IP) ip_nxt = i_wb.dat[1:0];
        ip_nxt = ip_nxt & ie_nxt;
    end

    always_comb begin
        rdata = '0;
        case (i_wb.adr)
            uart_pkg::REG_TXDATA: rdata[uart_pkg::FLAG_BIT] = tx_full;
            uart_pkg::REG_RXDATA: begin
                rdata[uart_pkg::FLAG_BIT] = rx_empty;
                if (!rx_empty) begin
                    rdata[7:0] = rx_head.data;
                    rdata[uart_pkg::PERR_BIT] = rx_head.perr;
                    rdata[uart_pkg::FERR_BIT] = rx_head.ferr;
                end
            end
            uart_pkg::REG_TXCTRL: rdata = ctrl_word(o_tx_cfg, tx_thresh);
            uart_pkg::REG_RXCTRL: rdata = ctrl_word(o_rx_cfg, rx_thresh);
            uart_pkg::REG_IE:     rdata[1:0] = ie;
            uart_pkg::REG_IP:     rdata[1:0] = ip;
            uart_pkg::REG_SCALER: rdata = {1'b0, o_scaler};
            default:              rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_tx_cfg <= '0;
            o_rx_cfg <= '0;
            tx_thresh <= '0;
            rx_thresh <= '0;
            o_scaler <= '0;
            ie <= '0;
            ip <= '0;
            ack_q <= 1'b0;
        end else begin
            ie <= ie_nxt;
            ip <= ip_nxt;
            ack_q <= acc;
            if (wr && i_wb.adr == uart_pkg::REG_TXCTRL) begin
                o_tx_cfg <= '{ena: i_wb.dat[0], nstop: i_wb.dat[1], par: i_wb.dat[2]};
                tx_thresh <= i_wb.dat[uart_pkg::THRESH_LSB +: $bits(uart_pkg::thresh_t)];
            end
            if (wr && i_wb.adr == uart_pkg::REG_RXCTRL) begin
                o_rx_cfg <= '{ena: i_wb.dat[0], nstop: i_wb.dat[1], par: i_wb.dat[2]};
                rx_thresh <= i_wb.dat[uart_pkg::THRESH_LSB +: $bits(uart_pkg::thresh_t)];
            end
            if (o_scaler_restart) o_scaler <= i_wb.dat[30:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (acc) dat_q <= rdata;  // Head entry before the pop
    end

    assign o_wb  = '{ack: ack_q, dat: dat_q};
    assign o_irq = |ip;

endmodule

`default_nettype wire

/* source/uart_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_wb (
    input  wire logic              i_clk,
    input  wire logic              i_nrst,
    input  wire uart_pkg::wb_req_t i_wb,
    output uart_pkg::wb_rsp_t      o_wb,
    input  wire logic              i_rd,
    output logic                   o_td,
    output logic                   o_irq
);

    uart_pkg::line_cfg_t tx_cfg, rx_cfg;
    uart_pkg::rx_entry_t rx_entry;
    uart_pkg::scaler_t scaler;
    logic [7:0] tx_data;
    logic tx_empty, tx_pop, tx_idle, tx_tick;
    logic rx_push, rx_idle, rx_tick;
    logic scaler_restart;

    uart_regs u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_wb(i_wb), .o_wb(o_wb),
        .i_tx_pop(tx_pop), .i_rx_push(rx_push), .i_rx_entry(rx_entry),
        .o_tx_cfg(tx_cfg), .o_rx_cfg(rx_cfg), .o_tx_empty(tx_empty), .o_tx_data(tx_data),
        .o_scaler(scaler), .o_scaler_restart(scaler_restart), .o_irq(o_irq)
    );

    baud_gen u_baud (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scaler(scaler), .i_restart(scaler_restart),
        .i_rd(i_rd), .i_rx_idle(rx_idle), .i_tx_idle(tx_idle), .i_tx_empty(tx_empty),
        .o_tx_tick(tx_tick), .o_rx_tick(rx_tick)
    );

    uart_tx u_tx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_tick(tx_tick), .i_cfg(tx_cfg),
        .i_empty(tx_empty), .i_data(tx_data), .o_pop(tx_pop), .o_td(o_td), .o_idle(tx_idle)
    );

    uart_rx u_rx (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_tick(rx_tick), .i_cfg(rx_cfg),
        .i_rd(i_rd), .o_push(rx_push), .o_entry(rx_entry), .o_idle(rx_idle)
    );

endmodule

`default_nettype wire

/* verif/uart_wb_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_wb_chk (
    input wire logic              i_clk,
    input wire logic              i_nrst,
    input wire uart_pkg::wb_req_t i_req,
    input wire uart_pkg::wb_rsp_t i_rsp,
    input wire logic              i_irq,
    input wire logic [1:0]        i_ie
);

    // Ack answers a strobed cycle of the previous clock
    ack_after_strobe: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp.ack |-> $past(i_req.cyc && i_req.stb))
        else $error("Ack without a strobed cycle before it");

    ack_single: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_rsp.ack |=> !i_rsp.ack)
        else $error("Ack high for two cycles in a row");

    irq_masked: assert property (@(posedge i_clk) disable iff (!i_nrst)
        (i_ie == 2'b00) |-> !i_irq)
        else $error("Interrupt high with both enables clear");

endmodule

`default_nettype wire

/* verif/uart_wb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_wb_tb;

    localparam int SEED = 91156;
    localparam int CLK_PERIOD = 4;
    localparam int TEST_SCALER = 4;
    localparam int BIT_CYCLES = 2 * TEST_SCALER;
    localparam int TX_FRAMES = 6;
    localparam int RX_FRAMES = 4;
    // All frames of the run plus the idle window of the FIFO test
    localparam int TOTAL_FRAMES = 2 * TX_FRAMES + RX_FRAMES + 2 + 15 + 16 + 3 + 2;
    localparam int TIMEOUT_NS = TOTAL_FRAMES * 12 * BIT_CYCLES * CLK_PERIOD + 20000;
    localparam logic [31:0] FLAG_WORD = 32'h8000_0000;

    logic clk;
    logic nrst;
    uart_pkg::wb_req_t wb_req;
    uart_pkg::wb_rsp_t wb_rsp;
    logic rd;
    logic td;
    logic irq;
    int td_falls = 0;

    uart_wb uut (
        .i_clk(clk), .i_nrst(nrst), .i_wb(wb_req), .o_wb(wb_rsp),
        .i_rd(rd), .o_td(td), .o_irq(irq)
    );

    bind uart_wb uart_wb_chk u_chk (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req(i_wb), .i_rsp(o_wb),
        .i_irq(o_irq), .i_ie(u_regs.ie)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(negedge td) td_falls <= td_falls + 1;  // Any falling edge on the line

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
            $display("TESTS FAILED");
            $fatal(1, "Check failed");
        end
    endtask

    // Control word: ena bit 0, nstop bit 1, par bit 2, threshold at bit 16
    function automatic logic [31:0] make_ctrl(input logic ena, input logic nstop,
                                              input logic par, input logic [2:0] thresh);
        return {13'd0, thresh, 13'd0, par, nstop, ena};
    endfunction

    function automatic logic [31:0] rx_word(input logic [7:0] data, input logic perr,
                                            input logic ferr);
        return {22'd0, ferr, perr, data};
    endfunction

    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int n;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!wb_rsp.ack && n < 8);
        assert (wb_rsp.ack) else abort_run("Bus access got no ack within 8 cycles");
        check_value("o_wb.ack latency", 32'd1, 32'(n));
        rdat = wb_rsp.dat;
        wb_req = '0;  // Drop the strobe in the ack cycle
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        logic [31:0] rsp_dat;
        wb_access(1'b1, adr, dat, rsp_dat);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, 32'd0, dat);
    endtask

    // Start, data, parity, one stop bit, then one idle bit
    task automatic send_frame(input logic [7:0] data, input logic bad_par, input logic bad_stop);
        logic [11:0] bits;
        int i;
        bits = {1'b1, ~bad_stop, (^data) ^ bad_par, data, 1'b0};
        @(negedge clk);
        for (i = 0; i < 12; i++) begin
            rd = bits[0];
            bits = bits >> 1;
            repeat (BIT_CYCLES) @(negedge clk);
        end
    endtask

    task automatic recv_frame(input logic par, input logic nstop, input logic [7:0] exp);
        logic [7:0] d;
        int i;
        @(negedge td);
        repeat (TEST_SCALER) @(negedge clk);  // Near the centre of the start bit
        check_value("o_td start bit", 32'd0, 32'(td));
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CYCLES) @(negedge clk);
            d = {td, d[7:1]};
        end
        check_value("o_td data byte", 32'(exp), 32'(d));
        if (par) begin
            repeat (BIT_CYCLES) @(negedge clk);
            check_value("o_td parity bit", 32'(^exp), 32'(td));
        end
        repeat (BIT_CYCLES) @(negedge clk);
        check_value("o_td stop bit", 32'd1, 32'(td));
        if (nstop) begin
            repeat (BIT_CYCLES) @(negedge clk);
            check_value("o_td second stop bit", 32'd1, 32'(td));
        end
    endtask

    task automatic reset_values();
        logic [31:0] rdat;
        int a;
        check_value("o_td", 32'd1, 32'(td));
        check_value("o_irq", 32'd0, 32'(irq));
        wb_read(uart_pkg::REG_TXDATA, rdat);
        check_value("txdata", 32'd0, rdat);
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata", FLAG_WORD, rdat);
        for (a = 2; a <= 6; a++) begin  // Control, ie, ip and scaler
            wb_read(3'(a), rdat);
            check_value($sformatf("register %0d", a), 32'd0, rdat);
        end
    endtask

    task automatic transmit_frames(input logic par, input logic nstop);
        logic [7:0] sent[$];
        int i;
        int j;
        for (i = 0; i < TX_FRAMES; i++) begin
            sent.push_back(8'($urandom()));
        end
        wb_write(uart_pkg::REG_TXCTRL, make_ctrl(1'b1, nstop, par, 3'd0));
        fork
            begin
                for (i = 0; i < TX_FRAMES; i++) begin
                    wb_write(uart_pkg::REG_TXDATA, 32'(sent[i]));
                end
            end
            begin
                for (j = 0; j < TX_FRAMES; j++) begin
                    recv_frame(par, nstop, sent[j]);
                end
            end
        join
    endtask

    task automatic receive_frames();
        logic [7:0] sent[$];
        logic [31:0] rdat;
        int i;
        wb_write(uart_pkg::REG_RXCTRL, make_ctrl(1'b1, 1'b0, 1'b1, 3'd0));
        for (i = 0; i < RX_FRAMES; i++) begin
            sent.push_back(8'($urandom()));
            send_frame(sent[i], 1'b0, 1'b0);
        end
        for (i = 0; i < RX_FRAMES; i++) begin
            wb_read(uart_pkg::REG_RXDATA, rdat);
            check_value("rxdata", rx_word(sent[i], 1'b0, 1'b0), rdat);
        end
        send_frame(8'h5a, 1'b1, 1'b0);
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata with parity error", rx_word(8'h5a, 1'b1, 1'b0), rdat);
        send_frame(8'hc3, 1'b0, 1'b1);
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata with stop error", rx_word(8'hc3, 1'b0, 1'b1), rdat);
    endtask

    task automatic fifo_limits();
        logic [7:0] sent[$];
        logic [31:0] rdat;
        int i;
        int falls;
        wb_write(uart_pkg::REG_TXCTRL, make_ctrl(1'b0, 1'b0, 1'b0, 3'd0));
        for (i = 0; i < 16; i++) begin
            sent.push_back(8'($urandom()));
            wb_write(uart_pkg::REG_TXDATA, 32'(sent[i]));
            if (i >= 13) begin
                wb_read(uart_pkg::REG_TXDATA, rdat);
                check_value("txdata full flag", (i >= 14) ? FLAG_WORD : 32'd0, rdat);
            end
        end
        wb_write(uart_pkg::REG_TXCTRL, make_ctrl(1'b1, 1'b0, 1'b0, 3'd0));
        for (i = 0; i < 15; i++) begin
            recv_frame(1'b0, 1'b0, sent[i]);
        end
        falls = td_falls;
        repeat (3 * 12 * BIT_CYCLES) @(negedge clk);
        check_value("o_td edges after 15 frames", 32'(falls), 32'(td_falls));

        sent.delete();
        for (i = 0; i < 16; i++) begin  // Last one meets a full FIFO
            sent.push_back(8'($urandom()));
            send_frame(sent[i], 1'b0, 1'b0);
        end
        for (i = 0; i < 15; i++) begin
            wb_read(uart_pkg::REG_RXDATA, rdat);
            check_value("rxdata", rx_word(sent[i], 1'b0, 1'b0), rdat);
        end
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata empty flag", FLAG_WORD, rdat);
    endtask

    task automatic interrupt_flags();
        logic [31:0] rdat;
        wb_write(uart_pkg::REG_RXCTRL, make_ctrl(1'b1, 1'b0, 1'b1, 3'd1));
        wb_write(uart_pkg::REG_IE, 32'h2);
        send_frame(8'h11, 1'b0, 1'b0);
        check_value("o_irq after one byte", 32'd0, 32'(irq));
        send_frame(8'h22, 1'b0, 1'b0);
        check_value("o_irq after two bytes", 32'd1, 32'(irq));
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata", rx_word(8'h11, 1'b0, 1'b0), rdat);
        wb_read(uart_pkg::REG_RXDATA, rdat);
        check_value("rxdata", rx_word(8'h22, 1'b0, 1'b0), rdat);
        wb_write(uart_pkg::REG_IP, 32'd0);
        check_value("o_irq after ip clear", 32'd0, 32'(irq));
        wb_write(uart_pkg::REG_TXCTRL, make_ctrl(1'b0, 1'b0, 1'b0, 3'd2));
        wb_write(uart_pkg::REG_IE, 32'h1);
        check_value("o_irq with tx FIFO below threshold", 32'd1, 32'(irq));
    endtask

    initial begin
        #(TIMEOUT_NS);
        abort_run("Watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(SEED));
        clk = 1'b0;
        nrst = 1'b0;
        wb_req = '0;
        rd = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;
        reset_values();
        wb_write(uart_pkg::REG_SCALER, 32'(TEST_SCALER));
        transmit_frames(1'b1, 1'b1);
        transmit_frames(1'b0, 1'b0);
        receive_frames();
        fifo_limits();
        interrupt_flags();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_wb.f */
source/uart_pkg.sv
source/byte_fifo.sv
source/baud_gen.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_regs.sv
source/uart_wb.sv
verif/uart_wb_chk.sv
verif/uart_wb_tb.sv

/* Makefile */
sim:
	verilator --binary --timing --assert -f uart_wb.f --top-module uart_wb_tb -o uart_wb_sim
	./obj_dir/uart_wb_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean
